/* source/ptw_defines.svh */
// width macros for the Sv32 page-table walker
// address, PPN, VPN segment, level count, ASID and cache split

`ifndef PTW_DEFINES_SVH
`define PTW_DEFINES_SVH

// data width of the core and of one PTE
`define PTW_XLEN 32

// physical address width
`define PTW_PLEN 34
// physical page number width
`define PTW_PPNW 22

// one VPN segment indexes 1024 PTEs of 4 bytes
`define PTW_VPN_SEG 10
`define PTW_PG_OFFS 12
// two levels, root first
`define PTW_LEVELS 2

`define PTW_ASIDW 9

// index and tag together cover the physical address
`define PTW_IDX_W 12
`define PTW_TAG_W 22

`endif

/* source/ptw_mem_pkg.sv */
// request and response structs of the walker's data-cache port
// single outstanding read, no write path

`default_nettype none

`include "ptw_defines.svh"

package ptw_mem_pkg;

  // ----------------------------------------
  // walker to cache
  // ----------------------------------------
  // tag follows index by one cycle
  typedef struct packed {
    logic                   req;
    logic [`PTW_IDX_W-1:0]  index;
    logic [`PTW_TAG_W-1:0]  tag;
    logic                   tag_valid;
  } mem_req_t;

  // ----------------------------------------
  // cache to walker
  // ----------------------------------------
  // one rvalid per granted request
  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [`PTW_XLEN-1:0]   rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* source/ptw_pte_pkg.sv */
// Sv32 PTE layout, virtual address split, TLB update word
// and the page-table level index

`default_nettype none

`include "ptw_defines.svh"

package ptw_pte_pkg;

  // level 0 is the root table
  typedef logic [$clog2(`PTW_LEVELS)-1:0] level_t;

  // ----------------------------------------
  // page table entry
  // ----------------------------------------
  typedef struct packed {
    logic [`PTW_PPNW-1:0] ppn;
    // reserved for supervisor software
    logic [1:0]           rsw;
    logic                 d;
    logic                 a;
    logic                 g;
    logic                 u;
    logic                 x;
    logic                 w;
    logic                 r;
    logic                 v;
  } pte_t;

  // virtual address as seen by the walk
  typedef struct packed {
    logic [`PTW_VPN_SEG-1:0] vpn1;
    logic [`PTW_VPN_SEG-1:0] vpn0;
    logic [`PTW_PG_OFFS-1:0] offset;
  } vaddr_t;

  // ----------------------------------------
  // shared TLB refill
  // ----------------------------------------
  typedef struct packed {
    logic                        valid;
    // 4 MiB mapping found at the root
    logic                        is_superpage;
    logic [2*`PTW_VPN_SEG-1:0]   vpn;
    logic [`PTW_ASIDW-1:0]       asid;
    // leaf PTE, g widened over the whole walk
    pte_t                        content;
  } tlb_update_t;

endpackage

`default_nettype wire

/* source/ptw_level_ctr.sv */
// page-table level counter
// restarts at the root and flags the last level

`default_nettype none

`include "ptw_defines.svh"

module ptw_level_ctr (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                start_i,
  input  wire logic                descend_i,
  output ptw_pte_pkg::level_t      level_o,
  output logic                     at_last_o
);

  import ptw_pte_pkg::*;

  level_t level_q;

  // start wins, a new walk always begins at the root
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= '0;
    end else if (start_i) begin
      level_q <= '0;
    end else if (descend_i) begin
      level_q <= level_q + 1'b1;
    end
  end

  assign level_o   = level_q;
  // leaf table reached, no pointer may follow
  assign at_last_o = (level_q == level_t'(`PTW_LEVELS - 1));

  // the FSM must turn a pointer at the last level into a fault
  a_no_descend_at_last: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    descend_i |-> !at_last_o
  );

endmodule

`default_nettype wire

/* source/ptw_pte_check.sv */
// classification of the fetched PTE
// validity, leaf or pointer, permission and superpage alignment

`default_nettype none

`include "ptw_defines.svh"

module ptw_pte_check (
  input  ptw_pte_pkg::pte_t    pte_i,
  input  ptw_pte_pkg::level_t  level_i,
  input  wire logic            at_last_i,
  input  wire logic            is_instr_i,
  input  wire logic            is_store_i,
  input  wire logic            mxr_i,
  output logic                 invalid_o,
  output logic                 is_leaf_o,
  output logic                 fault_o,
  output logic                 pointer_at_last_o
);

  logic perm_fault;
  logic store_fault;
  logic misaligned;

  // ----------------------------------------
  // encoding
  // ----------------------------------------
  // v clear, or write-only which is reserved
  assign invalid_o = !pte_i.v || (!pte_i.r && pte_i.w);

  // any of r or x marks a leaf
  assign is_leaf_o = pte_i.r || pte_i.x;

  // pointer with no table left below it
  assign pointer_at_last_o = !invalid_o && !is_leaf_o && at_last_i;

  // ----------------------------------------
  // leaf permissions
  // ----------------------------------------
  always_comb begin
    perm_fault  = 1'b0;
    store_fault = 1'b0;
    if (is_instr_i) begin
      // fetch needs execute and the accessed bit
      perm_fault = !(pte_i.x && pte_i.a);
    end else begin
      // load needs readable, or executable with MXR
      perm_fault = !(pte_i.a && (pte_i.r || (pte_i.x && mxr_i)));
      // a and d are left to software, so a clean page faults on store
      store_fault = is_store_i && !(pte_i.w && pte_i.d);
    end
  end

  // 4 MiB leaf must have its low PPN segment cleared
  assign misaligned = (level_i == '0) && (pte_i.ppn[`PTW_VPN_SEG-1:0] != '0);

  // only meaningful together with is_leaf_o
  assign fault_o = is_leaf_o && (perm_fault || store_fault || misaligned);

endmodule

`default_nettype wire

/* source/ptw_walk_regs.sv */
// walk context registers and PTE pointer
// registered cache response and TLB update assembly

`default_nettype none

`include "ptw_defines.svh"

module ptw_walk_regs (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  start_i,
  input  wire logic                  descend_i,
  input  wire logic                  tag_valid_i,
  input  wire logic                  req_i,
  input  wire logic                  update_valid_i,
  input  ptw_pte_pkg::vaddr_t        vaddr_i,
  input  wire logic [`PTW_PPNW-1:0]  satp_ppn_i,
  input  wire logic [`PTW_ASIDW-1:0] asid_i,
  input  wire logic                  itlb_req_i,
  input  ptw_pte_pkg::level_t        level_i,
  input  ptw_mem_pkg::mem_rsp_t      mem_rsp_i,
  output ptw_mem_pkg::mem_req_t      mem_req_o,
  output ptw_pte_pkg::pte_t          pte_o,
  output logic                       rvalid_o,
  output logic                       is_instr_o,
  output ptw_pte_pkg::vaddr_t        update_vaddr_o,
  output ptw_pte_pkg::tlb_update_t   tlb_update_o
);

  import ptw_pte_pkg::*;

  vaddr_t                 vaddr_q;
  logic [`PTW_ASIDW-1:0]  asid_q;
  logic [`PTW_PLEN-1:0]   pptr_q;
  logic                   is_instr_q;
  logic                   global_q;
  logic                   rvalid_q;
  logic [`PTW_XLEN-1:0]   rdata_q;
  pte_t                   pte_q;

  assign pte_q = pte_t'(rdata_q);

  // ----------------------------------------
  // walk context
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      is_instr_q <= 1'b0;
      global_q   <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      // response is used one cycle after the port
      rvalid_q <= mem_rsp_i.rvalid;
      if (start_i) begin
        is_instr_q <= itlb_req_i;
        global_q   <= 1'b0;
      end else if (descend_i) begin
        global_q   <= global_q | pte_q.g;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= mem_rsp_i.rdata;
    if (start_i) begin
      vaddr_q <= vaddr_i;
      asid_q  <= asid_i;
      // root table entry, word aligned
      pptr_q  <= {satp_ppn_i, vaddr_i.vpn1, 2'b00};
    end else if (descend_i) begin
      pptr_q  <= {pte_q.ppn, vaddr_q.vpn0, 2'b00};
    end
  end

  // ----------------------------------------
  // cache request and outputs
  // ----------------------------------------
  always_comb begin
    mem_req_o.req       = req_i;
    mem_req_o.index     = pptr_q[`PTW_IDX_W-1:0];
    mem_req_o.tag       = pptr_q[`PTW_IDX_W+`PTW_TAG_W-1:`PTW_IDX_W];
    mem_req_o.tag_valid = tag_valid_i;
  end

  assign pte_o          = pte_q;
  assign rvalid_o       = rvalid_q;
  assign is_instr_o     = is_instr_q;
  assign update_vaddr_o = vaddr_q;

  always_comb begin
    tlb_update_o.valid        = update_valid_i;
    tlb_update_o.is_superpage = (level_i == '0);
    tlb_update_o.vpn          = {vaddr_q.vpn1, vaddr_q.vpn0};
    tlb_update_o.asid         = asid_q;
    tlb_update_o.content      = pte_q;
    // global if any table on the way said so
    tlb_update_o.content.g    = pte_q.g | global_q;
  end

  // tag goes out only behind an accepted request
  a_tag_after_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tag_valid_i |-> $past(req_i && mem_rsp_i.gnt)
  );

endmodule

`default_nettype wire

/* source/ptw_fsm.sv */
// walk state machine
// miss detection, cache handshake, PTE decision and flush

`default_nettype none

`include "ptw_defines.svh"

module ptw_fsm (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic flush_i,
  input  wire logic enable_translation_i,
  input  wire logic tlb_access_i,
  input  wire logic tlb_hit_i,
  input  wire logic gnt_i,
  input  wire logic rvalid_i,
  input  wire logic invalid_i,
  input  wire logic is_leaf_i,
  input  wire logic fault_i,
  input  wire logic pointer_at_last_i,
  output logic      start_o,
  output logic      descend_o,
  output logic      req_o,
  output logic      tag_valid_o,
  output logic      update_valid_o,
  output logic      error_o,
  output logic      miss_o,
  output logic      active_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    PROPAGATE_ERROR,
    WAIT_RVALID,
    LATENCY
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   tag_valid_q;
  logic   tlb_miss;

  assign tlb_miss = tlb_access_i && !tlb_hit_i && enable_translation_i;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d        = state_q;
    start_o        = 1'b0;
    descend_o      = 1'b0;
    req_o          = 1'b0;
    update_valid_o = 1'b0;
    error_o        = 1'b0;
    miss_o         = 1'b0;
    case (state_q)
      IDLE: begin
        if (tlb_miss && !flush_i) begin
          start_o = 1'b1;
          miss_o  = 1'b1;
          state_d = WAIT_GRANT;
        end
      end
      WAIT_GRANT: begin
        // hold the request through back-pressure
        req_o = 1'b1;
        if (gnt_i) begin
          state_d = PTE_LOOKUP;
        end
      end
      PTE_LOOKUP: begin
        if (rvalid_i) begin
          if (invalid_i || (is_leaf_i && fault_i) || (!is_leaf_i && pointer_at_last_i)) begin
            state_d = PROPAGATE_ERROR;
          end else if (is_leaf_i) begin
            update_valid_o = !flush_i;
            state_d        = LATENCY;
          end else begin
            // pointer, one level down
            descend_o = !flush_i;
            state_d   = WAIT_GRANT;
          end
        end
      end
      PROPAGATE_ERROR: begin
        error_o = !flush_i;
        state_d = LATENCY;
      end
      // drain the response of a flushed walk
      WAIT_RVALID: begin
        if (rvalid_i) begin
          state_d = IDLE;
        end
      end
      LATENCY: state_d = IDLE;
      default: state_d = IDLE;
    endcase

    // a response still owed must be absorbed before the next walk
    if (flush_i) begin
      if (((state_q == PTE_LOOKUP || state_q == WAIT_RVALID) && !rvalid_i) ||
          (state_q == WAIT_GRANT && gnt_i)) begin
        state_d = WAIT_RVALID;
      end else begin
        state_d = LATENCY;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      tag_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // tag follows the grant, even on flush
      tag_valid_q <= (state_q == WAIT_GRANT) && gnt_i;
    end
  end

  assign tag_valid_o = tag_valid_q;
  assign active_o    = (state_q != IDLE);

  // one outcome per walk, never two in a row
  a_single_outcome: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (update_valid_o || error_o) |=> !(update_valid_o || error_o)
  );

  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_o && !gnt_i && !flush_i) |=> req_o
  );

endmodule

`default_nettype wire

/* source/ptw_top.sv */
// Sv32 page-table walker top level
// FSM, level counter, PTE checker and walk registers

`default_nettype none

`include "ptw_defines.svh"

module ptw_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  flush_i,
  input  wire logic                  enable_translation_i,
  input  wire logic                  tlb_access_i,
  input  wire logic                  tlb_hit_i,
  input  ptw_pte_pkg::vaddr_t        tlb_vaddr_i,
  input  wire logic                  itlb_req_i,
  input  wire logic                  lsu_is_store_i,
  input  wire logic [`PTW_PPNW-1:0]  satp_ppn_i,
  input  wire logic [`PTW_ASIDW-1:0] asid_i,
  input  wire logic                  mxr_i,
  input  ptw_mem_pkg::mem_rsp_t      mem_rsp_i,
  output ptw_mem_pkg::mem_req_t      mem_req_o,
  output ptw_pte_pkg::tlb_update_t   tlb_update_o,
  output ptw_pte_pkg::vaddr_t        update_vaddr_o,
  output logic                       ptw_active_o,
  output logic                       walking_instr_o,
  output logic                       ptw_error_o,
  output logic                       tlb_miss_o
);

  import ptw_pte_pkg::*;

  // FSM strobes
  logic   start;
  logic   descend;
  logic   req;
  logic   tag_valid;
  logic   update_valid;
  // registered response
  pte_t   pte_q;
  logic   rvalid_q;
  level_t level;
  logic   at_last;
  // PTE decision
  logic   invalid;
  logic   is_leaf;
  logic   fault;
  logic   pointer_at_last;

  ptw_fsm u_fsm (
    .clk_i, .rst_ni, .flush_i, .enable_translation_i, .tlb_access_i, .tlb_hit_i,
    .gnt_i             (mem_rsp_i.gnt),
    .rvalid_i          (rvalid_q),
    .invalid_i         (invalid),
    .is_leaf_i         (is_leaf),
    .fault_i           (fault),
    .pointer_at_last_i (pointer_at_last),
    .start_o           (start),
    .descend_o         (descend),
    .req_o             (req),
    .tag_valid_o       (tag_valid),
    .update_valid_o    (update_valid),
    .error_o           (ptw_error_o),
    .miss_o            (tlb_miss_o),
    .active_o          (ptw_active_o)
  );

  ptw_level_ctr u_level_ctr (
    .clk_i, .rst_ni,
    .start_i   (start),
    .descend_i (descend),
    .level_o   (level),
    .at_last_o (at_last)
  );

  ptw_pte_check u_pte_check (
    .pte_i             (pte_q),
    .level_i           (level),
    .at_last_i         (at_last),
    .is_instr_i        (walking_instr_o),
    .is_store_i        (lsu_is_store_i),
    .mxr_i             (mxr_i),
    .invalid_o         (invalid),
    .is_leaf_o         (is_leaf),
    .fault_o           (fault),
    .pointer_at_last_o (pointer_at_last)
  );

  ptw_walk_regs u_walk_regs (
    .clk_i, .rst_ni, .satp_ppn_i, .asid_i, .itlb_req_i, .mem_rsp_i, .mem_req_o,
    .start_i        (start),
    .descend_i      (descend),
    .tag_valid_i    (tag_valid),
    .req_i          (req),
    .update_valid_i (update_valid),
    .vaddr_i        (tlb_vaddr_i),
    .level_i        (level),
    .pte_o          (pte_q),
    .rvalid_o       (rvalid_q),
    .is_instr_o     (walking_instr_o),
    .update_vaddr_o (update_vaddr_o),
    .tlb_update_o   (tlb_update_o)
  );

endmodule

`default_nettype wire

/* dv/ptw_mem_model.sv */
// page-table memory for the walker testbench
// grant after 0 to 3 cycles, one rvalid 1 to 3 cycles after tag_valid

`default_nettype none

`include "ptw_defines.svh"

module ptw_mem_model #(
  parameter logic [31:0] SEED = 32'ha9aa_9da0
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  ptw_mem_pkg::mem_req_t  mem_req_i,
  output ptw_mem_pkg::mem_rsp_t  mem_rsp_o
);

  import ptw_mem_pkg::*;

  // word array covering PPN 0 to 3
  logic [31:0]           mem [0:4095];
  logic [31:0]           rng_q;
  logic [1:0]            gnt_wait_q;
  logic [1:0]            rsp_wait_q;
  logic [`PTW_IDX_W-1:0] index_q;
  logic [11:0]           word_idx;
  logic                  gnt;
  logic                  rvalid_q;
  logic [31:0]           rdata_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // background pattern, every address gets its own word
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = {i[15:0], ~i[15:0]} ^ 32'h5a5a_0000;
    end
  end

  assign gnt      = mem_req_i.req && (gnt_wait_q == 2'd0);
  // physical address is {tag, index}, word select drops the byte bits
  assign word_idx = {mem_req_i.tag[1:0], index_q[`PTW_IDX_W-1:2]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rng_q      <= SEED;
      gnt_wait_q <= 2'd0;
      rsp_wait_q <= 2'd0;
      rvalid_q   <= 1'b0;
      rdata_q    <= '0;
      index_q    <= '0;
    end else begin
      rvalid_q <= 1'b0;
      if (mem_req_i.req) begin
        if (gnt) begin
          // next request waits a fresh random time
          gnt_wait_q <= rng_q[1:0];
          index_q    <= mem_req_i.index;
          rng_q      <= xorshift32(rng_q);
        end else begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
      end
      if (mem_req_i.tag_valid) begin
        rsp_wait_q <= 2'd1 + 2'(rng_q[3:2] % 3);
        rdata_q    <= mem[word_idx];
      end else if (rsp_wait_q != 2'd0) begin
        rsp_wait_q <= rsp_wait_q - 2'd1;
        if (rsp_wait_q == 2'd1) begin
          rvalid_q <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    mem_rsp_o.gnt    = gnt;
    mem_rsp_o.rvalid = rvalid_q;
    mem_rsp_o.rdata  = rdata_q;
  end

endmodule

`default_nettype wire

/* dv/tb_ptw.sv */
// testbench for the Sv32 page-table walker
// clock, reset, walk stimulus, watchdog and checking assertions

`default_nettype none

`include "ptw_defines.svh"

module tb_ptw;

  import ptw_pte_pkg::*;
  import ptw_mem_pkg::*;

  localparam int N_WALKS  = 20;
  localparam int K_UPDATE = 0;
  localparam int K_ERROR  = 1;
  localparam int K_NONE   = 2;
  // PTE flag bits d a g u x w r v
  localparam logic [7:0] F_V = 8'h01;
  localparam logic [7:0] F_R = 8'h02;
  localparam logic [7:0] F_W = 8'h04;
  localparam logic [7:0] F_X = 8'h08;
  localparam logic [7:0] F_G = 8'h20;
  localparam logic [7:0] F_A = 8'h40;
  localparam logic [7:0] F_D = 8'h80;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush;
  logic                  en_tr;
  logic                  access;
  logic                  hit;
  vaddr_t                vaddr;
  logic                  itlb_req;
  logic                  is_store;
  logic [`PTW_PPNW-1:0]  satp_ppn;
  logic [`PTW_ASIDW-1:0] asid;
  logic                  mxr;
  mem_req_t              mem_req;
  mem_rsp_t              mem_rsp;
  tlb_update_t           tlb_update;
  vaddr_t                update_vaddr;
  logic                  active;
  logic                  walking_instr;
  logic                  ptw_error;
  logic                  tlb_miss;

  // expected outcome of the current walk
  int                    exp_kind;
  logic [`PTW_PPNW-1:0]  exp_ppn;
  logic                  exp_super;
  logic                  exp_g;
  vaddr_t                exp_vaddr;
  logic [`PTW_ASIDW-1:0] exp_asid;
  logic                  miss_allowed;
  int                    n_outcome;
  int                    n_miss;
  int                    err_count;
  logic [31:0]           rng;

  ptw_top UUT (
    .clk_i, .rst_ni,
    .flush_i (flush), .enable_translation_i (en_tr), .tlb_access_i (access),
    .tlb_hit_i (hit), .tlb_vaddr_i (vaddr), .itlb_req_i (itlb_req),
    .lsu_is_store_i (is_store), .satp_ppn_i (satp_ppn), .asid_i (asid), .mxr_i (mxr),
    .mem_rsp_i (mem_rsp), .mem_req_o (mem_req), .tlb_update_o (tlb_update),
    .update_vaddr_o (update_vaddr), .ptw_active_o (active),
    .walking_instr_o (walking_instr), .ptw_error_o (ptw_error), .tlb_miss_o (tlb_miss)
  );

  ptw_mem_model u_mem (.clk_i, .rst_ni, .mem_req_i (mem_req), .mem_rsp_o (mem_rsp));

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_fail(input string msg);
    err_count++;
    $display("Fail %0t: %s", $time, msg);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  // PTE of a table at ppn, index vpn, only PPN 0 to 3 are backed
  task automatic write_pte(input logic [1:0] ppn, input logic [9:0] vpn,
                           input logic [21:0] pte_ppn, input logic [7:0] flags);
    u_mem.mem[{ppn, vpn}] = {pte_ppn, 2'b00, flags};
  endtask

  // ----------------------------------------
  // outcome and miss counting
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (tlb_update.valid || ptw_error) n_outcome++;
    if (tlb_miss) n_miss++;
  end

  a_miss_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_miss |-> miss_allowed) else report_fail("miss without a started walk");
  a_walking_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_miss |=> walking_instr == $past(itlb_req)) else report_fail("walking_instr wrong");
  a_update_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_update.valid |-> exp_kind == K_UPDATE) else report_fail("unexpected TLB update");
  a_error_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ptw_error |-> exp_kind == K_ERROR) else report_fail("unexpected page fault");
  a_one_outcome: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tlb_update.valid || ptw_error) |-> n_outcome == 0) else report_fail("second outcome");
  a_update_ppn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_update.valid |-> tlb_update.content.ppn == exp_ppn) else report_fail("wrong PPN");
  a_update_super: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_update.valid |-> tlb_update.is_superpage == exp_super)
    else report_fail("wrong superpage flag");
  a_update_g: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_update.valid |-> tlb_update.content.g == exp_g) else report_fail("wrong global bit");
  a_update_vpn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_update.valid |-> tlb_update.vpn == {exp_vaddr.vpn1, exp_vaddr.vpn0})
    else report_fail("wrong VPN");
  a_update_asid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_update.valid |-> tlb_update.asid == exp_asid) else report_fail("wrong ASID");
  a_update_vaddr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_update.valid |-> update_vaddr == exp_vaddr) else report_fail("wrong update vaddr");

  // one walk, flush_mode below zero means no flush
  // 0 flush in WAIT_GRANT, 1 in PTE_LOOKUP, 2 held on into WAIT_RVALID
  task automatic do_walk(input logic [9:0] vpn1, input logic [9:0] vpn0,
                         input logic instr, input logic store, input logic mxr_v,
                         input int kind, input logic [21:0] ppn, input logic sp,
                         input logic g, input int flush_mode);
    rng = xorshift32(rng);
    @(posedge clk_i);
    #1;
    exp_kind = kind;
    exp_ppn = ppn;
    exp_super = sp;
    exp_g = g;
    n_outcome = 0;
    n_miss = 0;
    miss_allowed = 1'b1;
    vaddr = {vpn1, vpn0, rng[11:0]};
    exp_vaddr = {vpn1, vpn0, rng[11:0]};
    asid = rng[20:12];
    exp_asid = rng[20:12];
    itlb_req = instr;
    is_store = store;
    mxr = mxr_v;
    access = 1'b1;
    @(posedge clk_i);
    #1;
    access = 1'b0;
    miss_allowed = 1'b0;
    // core moves on after the miss, the walk must run on its latched copy
    vaddr = ~vaddr;
    asid = ~asid;
    itlb_req = ~itlb_req;
    if (flush_mode >= 0) begin
      while ((flush_mode == 0) ? !mem_req.req : !mem_req.tag_valid) begin
        @(posedge clk_i);
        #1;
      end
      flush = 1'b1;
      repeat ((flush_mode == 2) ? 2 : 1) begin
        @(posedge clk_i);
        #1;
      end
      flush = 1'b0;
    end
    while (active) begin
      @(posedge clk_i);
      #1;
    end
    assert (n_miss == 1) else report_fail("miss not pulsed once");
    assert (n_outcome == ((kind == K_NONE) ? 0 : 1)) else report_fail("outcome count wrong");
  endtask

  // hit or disabled translation, no walk may start
  task automatic no_walk(input logic hit_v, input logic en_v);
    @(posedge clk_i);
    #1;
    access = 1'b1;
    hit = hit_v;
    en_tr = en_v;
    @(posedge clk_i);
    #1;
    access = 1'b0;
    hit = 1'b0;
    en_tr = 1'b1;
    assert (!active) else report_fail("walk started without a miss");
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    #(N_WALKS * 200 * 8);
    $display("watchdog expired, a walk never finished");
    $display("Something failed");
    $fatal(1, "timeout");
  end

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    flush = 1'b0;
    en_tr = 1'b1;
    access = 1'b0;
    hit = 1'b0;
    vaddr = '0;
    itlb_req = 1'b0;
    is_store = 1'b0;
    satp_ppn = 22'd1;
    asid = '0;
    mxr = 1'b0;
    exp_kind = K_NONE;
    exp_ppn = '0;
    exp_super = 1'b0;
    exp_g = 1'b0;
    exp_vaddr = '0;
    exp_asid = '0;
    miss_allowed = 1'b0;
    n_outcome = 0;
    n_miss = 0;
    err_count = 0;
    rng = 32'ha9aa_9da0;
    repeat (16) @(posedge clk_i);
    // root table at PPN 1, second level tables at PPN 2 and 3
    write_pte(2'd1, 10'd1, 22'd2, F_V | F_G);
    write_pte(2'd1, 10'd2, 22'hC00, F_V | F_R | F_A);
    write_pte(2'd1, 10'd3, 22'hC01, F_V | F_R | F_A);
    write_pte(2'd1, 10'd4, 22'd0, 8'h00);
    write_pte(2'd1, 10'd5, 22'hC00, F_V | F_W);
    write_pte(2'd1, 10'd6, 22'd3, F_V);
    write_pte(2'd1, 10'd7, 22'hC00, F_V | F_R | F_A);
    write_pte(2'd1, 10'd8, 22'hC00, F_V | F_R);
    write_pte(2'd1, 10'd9, 22'hC00, F_V | F_R | F_A);
    write_pte(2'd1, 10'd10, 22'hC00, F_V | F_X | F_A);
    write_pte(2'd2, 10'd5, 22'h12345, F_V | F_R | F_W | F_A | F_D);
    write_pte(2'd3, 10'd7, 22'd2, F_V);
    #1;
    rst_ni = 1'b1;

    // 4 KiB page through a global pointer
    do_walk(10'd1, 10'd5, 1'b0, 1'b1, 1'b0, K_UPDATE, 22'h12345, 1'b0, 1'b1, -1);
    // superpages, aligned then misaligned
    do_walk(10'd2, 10'h155, 1'b0, 1'b0, 1'b0, K_UPDATE, 22'hC00, 1'b1, 1'b0, -1);
    do_walk(10'd3, 10'h0aa, 1'b0, 1'b0, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    // invalid, write-only, pointer at last level
    do_walk(10'd4, 10'd0, 1'b0, 1'b0, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    do_walk(10'd5, 10'd0, 1'b0, 1'b0, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    do_walk(10'd6, 10'd7, 1'b0, 1'b0, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    // no x on fetch, no a, store to a clean read-only page
    do_walk(10'd7, 10'd1, 1'b1, 1'b0, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    do_walk(10'd8, 10'd2, 1'b0, 1'b0, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    do_walk(10'd9, 10'd3, 1'b0, 1'b1, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    // execute-only page, load without and with MXR, then a fetch
    do_walk(10'd10, 10'd4, 1'b0, 1'b0, 1'b0, K_ERROR, '0, 1'b0, 1'b0, -1);
    do_walk(10'd10, 10'd4, 1'b0, 1'b0, 1'b1, K_UPDATE, 22'hC00, 1'b1, 1'b0, -1);
    do_walk(10'd10, 10'd9, 1'b1, 1'b0, 1'b0, K_UPDATE, 22'hC00, 1'b1, 1'b0, -1);
    // flush in each waiting state, then a clean walk
    do_walk(10'd1, 10'd5, 1'b0, 1'b0, 1'b0, K_NONE, '0, 1'b0, 1'b0, 0);
    do_walk(10'd1, 10'd5, 1'b0, 1'b0, 1'b0, K_NONE, '0, 1'b0, 1'b0, 1);
    do_walk(10'd1, 10'd5, 1'b0, 1'b0, 1'b0, K_NONE, '0, 1'b0, 1'b0, 2);
    do_walk(10'd1, 10'd5, 1'b0, 1'b0, 1'b0, K_UPDATE, 22'h12345, 1'b0, 1'b1, -1);
    // hit, and a miss with translation off
    no_walk(1'b1, 1'b1);
    no_walk(1'b0, 1'b0);
    repeat (4) @(posedge clk_i);

    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/ptw_mem_pkg.sv
source/ptw_pte_pkg.sv
source/ptw_level_ctr.sv
source/ptw_pte_check.sv
source/ptw_walk_regs.sv
source/ptw_fsm.sv
source/ptw_top.sv
dv/ptw_mem_model.sv
dv/tb_ptw.sv
